//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_dcache -f verilog.f -o sim_tb_dcache
./obj_dir/sim_tb_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  exit 1
fi
exit 0

//--- src/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address geometry
`define DC_ADDR_W 36
`define DC_INDEX_W 4
`define DC_SETS (1 << `DC_INDEX_W)
`define DC_OFFSET_W 6
`define DC_WORD_SEL_W 2
`define DC_BYTE_OFF_W 4
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// ways and line layout
`define DC_WAYS 4
`define DC_WAY_W 2
`define DC_WORD_W 128
`define DC_WORDS_PER_LINE 4
`define DC_LINE_W 512

// memory slot packet fields and type codes
`define DC_PKT_ID_W 4
`define DC_PKT_NONE 3'b000
`define DC_PKT_WRITE 3'b001
`define DC_PKT_READ 3'b011
`define DC_PKT_ACK 3'b101
`define DC_PKT_READ_DATA 3'b110

`endif

//--- src/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_data_array (
  input  logic                      clk,
  input  logic [`DC_INDEX_W-1:0]    rd_index,
  input  logic [`DC_WAY_W-1:0]      rd_way,
  input  logic [`DC_WORD_SEL_W-1:0] rd_word_sel,
  input  logic                      wr_en,
  input  logic [`DC_INDEX_W-1:0]    wr_index,
  input  logic [`DC_WAY_W-1:0]      wr_way,
  input  logic [`DC_WORD_SEL_W-1:0] wr_word_sel,
  input  logic [`DC_WORD_W-1:0]     wr_word,
  output logic [`DC_WORD_W-1:0]     rd_word
);

  logic [`DC_WORD_W-1:0]               mem [`DC_SETS][`DC_WAYS][`DC_WORDS_PER_LINE];
  // one word from every way of the addressed set
  logic [`DC_WAYS-1:0][`DC_WORD_W-1:0] rd_set_q;

  // all ways are read before the way is known
  // the way is picked in the following cycle
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      rd_set_q[w] <= mem[rd_index][w][rd_word_sel];
    end
    // a read of the word being written returns the old value
    if (wr_en) begin
      mem[wr_index][wr_way][wr_word_sel] <= wr_word;
    end
  end

  // way select after the synchronous read
  assign rd_word = rd_set_q[rd_way];

endmodule

//--- src/dcache_miss_fsm.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_miss_fsm #(
  parameter logic [`DC_PKT_ID_W-1:0] id = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  dcache_types_pkg::dc_req_t req,
  input  logic [`DC_INDEX_W-1:0]    live_index,
  input  logic [`DC_WORD_SEL_W-1:0] live_word_sel,
  input  logic                      hit,
  input  logic [`DC_WAY_W-1:0]      hit_way,
  input  logic [`DC_WAY_W-1:0]      victim_way,
  input  logic                      victim_dirty,
  input  logic [`DC_TAG_W-1:0]      victim_tag,
  input  logic [`DC_WORD_W-1:0]     rd_word,
  input  logic [`DC_WORD_W-1:0]     merged_word,
  input  mem_packet_pkg::mem_pkt_t  mem_in,
  output mem_packet_pkg::mem_pkt_t  mem_out,
  output logic                      overwrite,
  output logic                      stall,
  output logic [`DC_INDEX_W-1:0]    rd_index,
  output logic [`DC_WAY_W-1:0]      rd_way,
  output logic [`DC_WORD_SEL_W-1:0] rd_word_sel,
  output logic                      wr_en,
  output logic [`DC_INDEX_W-1:0]    wr_index,
  output logic [`DC_WAY_W-1:0]      wr_way,
  output logic [`DC_WORD_SEL_W-1:0] wr_word_sel,
  output logic [`DC_WORD_W-1:0]     wr_word,
  output logic                      fill_done
);
  import dcache_types_pkg::*;
  import mem_packet_pkg::*;

  typedef enum logic [2:0] {
    idle,
    writing_back,
    wb_ack_wait,
    sending_fill_req,
    waiting_on_fill,
    filling
  } state_e;

  state_e state, next_state;
  // word counter, bit 2 marks all four words handled
  logic [2:0]                                    cnt;
  logic                                          cnt_step;
  logic [`DC_WAY_W-1:0]                          vway_q;
  logic [`DC_TAG_W-1:0]                          wb_tag_q;
  logic [`DC_WORDS_PER_LINE-1:0][`DC_WORD_W-1:0] wb_buf;
  logic [`DC_WORDS_PER_LINE-1:0][`DC_WORD_W-1:0] fill_buf;
  logic                                          fill_done_q;
  logic                                          miss_capture;
  logic                                          fill_capture;
  logic                                          req_active;
  logic                                          slot_free;
  logic                                          pkt_for_us;
  logic [`DC_ADDR_W-1:0]                         fill_addr;
  logic [`DC_ADDR_W-1:0]                         wb_addr;

  assign req_active = req.read || (req.store != st_none);
  assign slot_free  = (mem_in.ptype == pkt_none);
  assign pkt_for_us = (mem_in.id == id);

  // line addresses, the requester holds its request across the miss
  assign fill_addr = {req.addr.tag, req.addr.index, {`DC_OFFSET_W{1'b0}}};
  assign wb_addr   = {wb_tag_q, req.addr.index, {`DC_OFFSET_W{1'b0}}};

  always_comb begin
    next_state    = state;
    stall         = 1'b1;
    overwrite     = 1'b0;
    fill_done     = 1'b0;
    miss_capture  = 1'b0;
    fill_capture  = 1'b0;
    cnt_step      = 1'b0;
    mem_out.ptype = pkt_none;
    mem_out.id    = id;
    mem_out.addr  = fill_addr;
    mem_out.data  = wb_buf;
    // reads follow the live request unless the victim is being read out
    rd_index      = live_index;
    rd_word_sel   = live_word_sel;
    rd_way        = vway_q;
    wr_en         = 1'b0;
    wr_index      = req.addr.index;
    wr_way        = vway_q;
    wr_word_sel   = cnt[1:0];
    wr_word       = fill_buf[cnt[1:0]];
    unique case (state)
      idle: begin
        rd_way      = hit_way;
        wr_way      = hit_way;
        wr_word_sel = req.addr.word_sel;
        wr_word     = merged_word;
        if (fill_done_q) begin
          // tags and data are reread once after a fill, stall holds
          next_state = idle;
        end else if (req_active && !hit) begin
          miss_capture = 1'b1;
          if (victim_dirty) begin
            next_state  = writing_back;
            rd_index    = req.addr.index;
            rd_word_sel = '0;
          end else if (slot_free) begin
            overwrite     = 1'b1;
            mem_out.ptype = pkt_read;
            next_state    = waiting_on_fill;
          end else begin
            next_state = sending_fill_req;
          end
        end else begin
          stall = 1'b0;
          wr_en = hit && (req.store != st_none);
        end
      end
      writing_back: begin
        // word k arrives while word k+1 is launched
        rd_index    = req.addr.index;
        rd_word_sel = cnt[1:0] + `DC_WORD_SEL_W'(1);
        cnt_step    = !cnt[2];
        if (cnt[2] && slot_free) begin
          overwrite     = 1'b1;
          mem_out.ptype = pkt_write;
          mem_out.addr  = wb_addr;
          next_state    = wb_ack_wait;
        end
      end
      wb_ack_wait: begin
        // the fill read takes the slot of the ack
        if (pkt_for_us && (mem_in.ptype == pkt_ack)) begin
          overwrite     = 1'b1;
          mem_out.ptype = pkt_read;
          next_state    = waiting_on_fill;
        end
      end
      sending_fill_req: begin
        if (slot_free) begin
          overwrite     = 1'b1;
          mem_out.ptype = pkt_read;
          next_state    = waiting_on_fill;
        end
      end
      waiting_on_fill: begin
        // consume the line and release the slot with a none packet
        if (pkt_for_us && (mem_in.ptype == pkt_read_data)) begin
          overwrite    = 1'b1;
          fill_capture = 1'b1;
          next_state   = filling;
        end
      end
      filling: begin
        wr_en    = 1'b1;
        cnt_step = 1'b1;
        if (cnt[1:0] == 2'd3) begin
          fill_done  = 1'b1;
          next_state = idle;
        end
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state       <= idle;
      cnt         <= '0;
      vway_q      <= '0;
      fill_done_q <= 1'b0;
    end else begin
      state       <= next_state;
      fill_done_q <= fill_done;
      if (miss_capture) begin
        cnt    <= '0;
        vway_q <= victim_way;
      end else if (fill_capture) begin
        cnt <= '0;
      end else if (cnt_step) begin
        cnt <= cnt + 3'd1;
      end
    end
  end

  // victim tag, writeback line and fill line
  always_ff @(posedge clk) begin
    if (miss_capture) begin
      wb_tag_q <= victim_tag;
    end
    if ((state == writing_back) && !cnt[2]) begin
      wb_buf[cnt[1:0]] <= rd_word;
    end
    if (fill_capture) begin
      fill_buf <= mem_in.data;
    end
  end

endmodule

//--- src/dcache_req_decode.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_req_decode (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         r,
  input  dcache_types_pkg::dc_store_e  w_type,
  input  logic [`DC_ADDR_W-1:0]        addr,
  input  logic [`DC_WORD_W-1:0]        w_data,
  output dcache_types_pkg::dc_req_t    req,
  output logic [`DC_INDEX_W-1:0]       live_index,
  output logic [`DC_WORD_SEL_W-1:0]    live_word_sel
);
  import dcache_types_pkg::*;

  dc_addr_t              addr_f;
  logic                  read_q;
  dc_store_e             store_q;
  dc_addr_t              addr_q;
  logic [`DC_WORD_W-1:0] data_q;

  // field view of the incoming address
  assign addr_f = addr;

  // array reads start from the live address at the same edge
  assign live_index    = addr_f.index;
  assign live_word_sel = addr_f.word_sel;

  // request kind
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      read_q  <= 1'b0;
      store_q <= st_none;
    end else begin
      read_q  <= r;
      store_q <= w_type;
    end
  end

  // address and store data, only meaningful with a request kind
  always_ff @(posedge clk) begin
    addr_q <= addr_f;
    data_q <= w_data;
  end

  assign req.read  = read_q;
  assign req.store = store_q;
  assign req.addr  = addr_q;
  assign req.data  = data_q;

endmodule

//--- src/dcache_store_merge.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_store_merge (
  input  dcache_types_pkg::dc_req_t req,
  input  logic [`DC_WORD_W-1:0]     rd_word,
  output logic [`DC_WORD_W-1:0]     merged_word,
  output logic [`DC_WORD_W-1:0]     data_out
);
  import dcache_types_pkg::*;

  dc_word_u word;

  // read-modify-write on the word read in the previous cycle
  always_comb begin
    word = rd_word;
    unique case (req.store)
      st_lane32: begin
        // low 32 bits of store data into the selected lane
        word.lane[req.addr.word_sel] = req.data[31:0];
      end
      st_half36: begin
        // 36-bit value, zero-filled to the top of the half
        word.half[req.addr.word_sel[1]] = {28'h0, req.data[35:0]};
      end
      st_full: begin
        word = req.data;
      end
      default: begin
        word = rd_word;
      end
    endcase
  end

  assign merged_word = word;

  // loads see the array word unchanged
  assign data_out = rd_word;

endmodule

//--- src/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_array (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`DC_INDEX_W-1:0]    live_index,
  input  dcache_types_pkg::dc_req_t req,
  input  logic                      fill_done,
  output logic                      hit,
  output logic [`DC_WAY_W-1:0]      hit_way,
  output logic [`DC_WAY_W-1:0]      victim_way,
  output logic                      victim_dirty,
  output logic [`DC_TAG_W-1:0]      victim_tag
);
  import dcache_types_pkg::*;

  logic [`DC_TAG_W-1:0]                    tags [`DC_SETS][`DC_WAYS];
  logic [`DC_SETS-1:0][`DC_WAYS-1:0]       valid;
  logic [`DC_SETS-1:0][`DC_WAYS-1:0]       dirty;
  logic [`DC_SETS-1:0][`DC_WAY_W-1:0]      rr_ptr;
  // set read launched from the live index
  logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]      tag_rd_q;
  logic [`DC_WAYS-1:0]                     valid_rd_q;
  logic [`DC_WAYS-1:0]                     match;
  logic                                    store_hit;

  // tag compare against the registered request
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      match[w] = valid_rd_q[w] && (tag_rd_q[w] == req.addr.tag);
      if (match[w]) begin
        hit_way = `DC_WAY_W'(w);
      end
    end
  end

  assign hit       = |match;
  assign store_hit = hit && (req.store != st_none);

  // round robin victim, dirty only counts for a valid line
  assign victim_way   = rr_ptr[req.addr.index];
  assign victim_tag   = tag_rd_q[victim_way];
  assign victim_dirty = valid_rd_q[victim_way] && dirty[req.addr.index][victim_way];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid      <= '0;
      dirty      <= '0;
      rr_ptr     <= '0;
      valid_rd_q <= '0;
    end else begin
      valid_rd_q <= valid[live_index];
      if (store_hit) begin
        dirty[req.addr.index][hit_way] <= 1'b1;
      end
      // new line lands clean, next fill in this set takes the following way
      if (fill_done) begin
        valid[req.addr.index][victim_way] <= 1'b1;
        dirty[req.addr.index][victim_way] <= 1'b0;
        rr_ptr[req.addr.index]            <= victim_way + `DC_WAY_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      tag_rd_q[w] <= tags[live_index][w];
    end
    if (fill_done) begin
      tags[req.addr.index][victim_way] <= req.addr.tag;
    end
  end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top #(
  parameter logic [`DC_PKT_ID_W-1:0] id = '0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        r,
  input  dcache_types_pkg::dc_store_e w_type,
  input  logic [`DC_ADDR_W-1:0]       addr,
  input  logic [`DC_WORD_W-1:0]       w_data,
  output logic [`DC_WORD_W-1:0]       data_out,
  output logic                        stall,
  input  mem_packet_pkg::mem_pkt_t    mem_in,
  output mem_packet_pkg::mem_pkt_t    mem_out,
  output logic                        overwrite
);
  import dcache_types_pkg::*;

  dc_req_t                   req;
  logic [`DC_INDEX_W-1:0]    live_index;
  logic [`DC_WORD_SEL_W-1:0] live_word_sel;

  // lookup results
  logic                      hit;
  logic [`DC_WAY_W-1:0]      hit_way;
  logic [`DC_WAY_W-1:0]      victim_way;
  logic                      victim_dirty;
  logic [`DC_TAG_W-1:0]      victim_tag;
  logic                      fill_done;

  // data array ports
  logic [`DC_INDEX_W-1:0]    rd_index;
  logic [`DC_WAY_W-1:0]      rd_way;
  logic [`DC_WORD_SEL_W-1:0] rd_word_sel;
  logic                      wr_en;
  logic [`DC_INDEX_W-1:0]    wr_index;
  logic [`DC_WAY_W-1:0]      wr_way;
  logic [`DC_WORD_SEL_W-1:0] wr_word_sel;
  logic [`DC_WORD_W-1:0]     wr_word;
  logic [`DC_WORD_W-1:0]     rd_word;
  logic [`DC_WORD_W-1:0]     merged_word;

  dcache_req_decode u_decode (
    .clk, .rst, .r, .w_type, .addr, .w_data, .req, .live_index, .live_word_sel
  );

  dcache_tag_array u_tags (
    .clk, .rst, .live_index, .req, .fill_done,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
  );

  dcache_data_array u_data (
    .clk, .rd_index, .rd_way, .rd_word_sel,
    .wr_en, .wr_index, .wr_way, .wr_word_sel, .wr_word, .rd_word
  );

  dcache_miss_fsm #(.id(id)) u_fsm (
    .clk, .rst, .req, .live_index, .live_word_sel,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .rd_word, .merged_word, .mem_in, .mem_out, .overwrite, .stall,
    .rd_index, .rd_way, .rd_word_sel,
    .wr_en, .wr_index, .wr_way, .wr_word_sel, .wr_word, .fill_done
  );

  dcache_store_merge u_merge (
    .req, .rd_word, .merged_word, .data_out
  );

endmodule

//--- src/dcache_types_pkg.sv
`include "dcache_cfg.svh"

package dcache_types_pkg;

  // requester address as the cache sees it
  typedef struct packed {
    logic [`DC_TAG_W-1:0]      tag;
    logic [`DC_INDEX_W-1:0]    index;
    // selects one 128-bit word of the line
    logic [`DC_WORD_SEL_W-1:0] word_sel;
    logic [`DC_BYTE_OFF_W-1:0] byte_off;
  } dc_addr_t;

  // store kind, none means a plain load or no request
  typedef enum logic [1:0] {
    st_none   = 2'b00,
    st_lane32 = 2'b01,
    st_half36 = 2'b10,
    st_full   = 2'b11
  } dc_store_e;

  // request as held for the execute cycle
  typedef struct packed {
    logic                  read;
    dc_store_e             store;
    dc_addr_t              addr;
    logic [`DC_WORD_W-1:0] data;
  } dc_req_t;

  // one cache word, seen as 32-bit lanes or as 64-bit halves
  typedef union packed {
    logic [3:0][31:0] lane;
    logic [1:0][63:0] half;
  } dc_word_u;

endpackage

//--- src/mem_packet_pkg.sv
`include "dcache_cfg.svh"

package mem_packet_pkg;

  // packet type on the shared memory slot
  typedef enum logic [2:0] {
    pkt_none      = `DC_PKT_NONE,
    pkt_write     = `DC_PKT_WRITE,
    pkt_read      = `DC_PKT_READ,
    pkt_ack       = `DC_PKT_ACK,
    pkt_read_data = `DC_PKT_READ_DATA
  } pkt_type_e;

  // one slot entry, same layout in both directions
  typedef struct packed {
    pkt_type_e                ptype;
    // owner of the transaction
    logic [`DC_PKT_ID_W-1:0]  id;
    // line address, offset bits are zero for cache traffic
    logic [`DC_ADDR_W-1:0]    addr;
    // whole line, word 0 in the low bits
    logic [`DC_LINE_W-1:0]    data;
  } mem_pkt_t;

endpackage

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;
  import dcache_types_pkg::*;
  import mem_packet_pkg::*;

  logic                  clk;
  logic                  rst;
  logic                  r;
  dc_store_e             w_type;
  logic [`DC_ADDR_W-1:0] addr;
  logic [`DC_WORD_W-1:0] w_data;
  logic [`DC_WORD_W-1:0] data_out;
  logic                  stall;
  mem_pkt_t              mem_in;
  mem_pkt_t              mem_out;
  logic                  overwrite;

  int unsigned errors;
  int unsigned checks;
  int unsigned read_count;
  int unsigned write_count;
  mem_pkt_t    last_read;
  mem_pkt_t    last_write;
  // slot model state
  logic                 ow_s;
  mem_pkt_t             out_s;
  logic                 pend;
  int                   pend_dly;
  mem_pkt_t             pend_pkt;
  logic                 foreign;
  int                   busy_cnt;
  logic                 busy_en;
  int                   force_busy;
  logic [`DC_LINE_W-1:0] mem_lines [logic [`DC_ADDR_W-1:0]];
  logic [`DC_LINE_W-1:0] exp_lines [logic [`DC_ADDR_W-1:0]];

  dcache_top #(.id(4'h4)) dcache_top_i (
    .clk, .rst, .r, .w_type, .addr, .w_data, .data_out, .stall,
    .mem_in, .mem_out, .overwrite
  );

  always #2 clk = ~clk;

  // default line content built from every bit of the line address
  function automatic logic [`DC_LINE_W-1:0] default_line(input logic [`DC_ADDR_W-1:0] la);
    logic [`DC_LINE_W-1:0] l;
    for (int k = 0; k < 4; k++) begin
      l[128*k +: 128] = {4'hc, la[35:8], 32'h5a00_0000 ^ (32'(k) << 8),
                         la[31:0] ^ 32'hffff_0000, 28'h0, la[35:32] ^ 4'(k)};
    end
    return l;
  endfunction

  function automatic logic [`DC_ADDR_W-1:0] make_addr(input logic [25:0] tag,
      input logic [3:0] idx, input logic [1:0] ws);
    return {tag, idx, ws, 4'h0};
  endfunction

  function automatic logic [`DC_ADDR_W-1:0] line_of(input logic [`DC_ADDR_W-1:0] a);
    return {a[35:6], 6'h0};
  endfunction

  // expected word from the shadow copy of the requester's view
  function automatic logic [`DC_WORD_W-1:0] exp_word(input logic [`DC_ADDR_W-1:0] a);
    logic [`DC_LINE_W-1:0] l;
    l = exp_lines.exists(line_of(a)) ? exp_lines[line_of(a)] : default_line(line_of(a));
    return l[128*a[5:4] +: 128];
  endfunction

  task automatic check_word(input string name, input logic [`DC_WORD_W-1:0] got,
      input logic [`DC_WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_pkt(input string name, input mem_pkt_t got, input mem_pkt_t exp,
      input logic with_data);
    checks++;
    if (got.ptype !== exp.ptype || got.id !== exp.id || got.addr !== exp.addr ||
        (with_data && got.data !== exp.data)) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  // memory and slot model acting at the falling edge on what the last posedge took
  initial begin
    ow_s = 1'b0;
    forever begin
      @(negedge clk);
      if (ow_s && out_s.id == 4'h4) begin
        if (out_s.ptype == pkt_write) begin
          write_count++;
          last_write = out_s;
          mem_lines[out_s.addr] = out_s.data;
          pend_pkt = '{ptype: pkt_ack, id: 4'h4, addr: out_s.addr, data: '0};
        end else if (out_s.ptype == pkt_read) begin
          read_count++;
          last_read = out_s;
          pend_pkt = '{ptype: pkt_read_data, id: 4'h4, addr: out_s.addr,
                       data: mem_lines.exists(out_s.addr) ? mem_lines[out_s.addr]
                                                          : default_line(out_s.addr)};
        end
        if (out_s.ptype != pkt_none) begin
          pend     = 1'b1;
          pend_dly = $urandom_range(6, 1);
        end
        mem_in.ptype = pkt_none;
      end
      if (foreign) begin
        busy_cnt--;
        if (busy_cnt <= 0) begin
          foreign      = 1'b0;
          mem_in.ptype = pkt_none;
        end
      end else if (mem_in.ptype == pkt_none &&
                   (force_busy > 0 || (busy_en && $urandom_range(3, 0) == 0))) begin
        foreign    = 1'b1;
        busy_cnt   = (force_busy > 0) ? force_busy : int'($urandom_range(4, 1));
        force_busy = 0;
        mem_in     = '{ptype: pkt_write, id: 4'h7, addr: 36'h0_dead_0000, data: '0};
      end
      if (pend) begin
        if (pend_dly > 0) begin
          pend_dly--;
        end else if (mem_in.ptype == pkt_none) begin
          mem_in = pend_pkt;
          pend   = 1'b0;
        end
      end
      #1;
      ow_s  = overwrite;
      out_s = mem_out;
      // a strobe on a busy slot is only legal when consuming our own reply
      if (overwrite && mem_in.ptype != pkt_none &&
          !(mem_in.id == 4'h4 && (mem_in.ptype == pkt_ack || mem_in.ptype == pkt_read_data)))
      begin
        errors++;
        $display("overwrite pulsed while the slot held a foreign packet");
      end
    end
  end

  // the model starts a foreign spell at the next falling edge
  task automatic hold_slot_busy(input int cycles);
    @(posedge clk);
    force_busy = cycles;
  endtask

  // one request held while stall is high
  task automatic access(input logic rd, input dc_store_e st, input logic [`DC_ADDR_W-1:0] a,
      input logic [`DC_WORD_W-1:0] d, output logic [`DC_WORD_W-1:0] word,
      output logic first_stall);
    int n;
    @(negedge clk);
    r      = rd;
    w_type = st;
    addr   = a;
    w_data = d;
    @(negedge clk);
    first_stall = stall;
    n = 0;
    while (stall && n < 300) begin
      @(negedge clk);
      n++;
    end
    if (stall) begin
      $display("timeout while waiting for stall to fall");
      $display("Testbench failed");
      $finish;
    end
    word   = data_out;
    r      = 1'b0;
    w_type = st_none;
  endtask

  task automatic load_check(input string name, input logic [`DC_ADDR_W-1:0] a);
    logic [`DC_WORD_W-1:0] word;
    logic                  fs;
    access(1'b1, st_none, a, '0, word, fs);
    check_word(name, word, exp_word(a));
  endtask

  // store then update the shadow by the merge rules and reload after an idle cycle
  task automatic store_check(input dc_store_e st, input logic [`DC_ADDR_W-1:0] a,
      input logic [`DC_WORD_W-1:0] d);
    logic [`DC_WORD_W-1:0] word;
    logic [`DC_LINE_W-1:0] l;
    logic                  fs;
    access(1'b0, st, a, d, word, fs);
    word = exp_word(a);
    if (st == st_lane32) begin
      word[32*a[5:4] +: 32] = d[31:0];
    end else if (st == st_half36) begin
      word[64*a[5] +: 64] = {28'h0, d[35:0]};
    end else begin
      word = d;
    end
    l = exp_lines.exists(line_of(a)) ? exp_lines[line_of(a)] : default_line(line_of(a));
    l[128*a[5:4] +: 128] = word;
    exp_lines[line_of(a)] = l;
    @(negedge clk);
    load_check("data_out", a);
  endtask

  task automatic test_reset_state();
    check_level("stall", stall, 1'b0);
    check_level("overwrite", overwrite, 1'b0);
    check_level("no_packets", (read_count + write_count) == 0, 1'b1);
  endtask

  task automatic test_cold_load();
    logic [`DC_ADDR_W-1:0] a;
    a = make_addr(26'h12_3456, 4'd3, 2'd2);
    load_check("data_out", a);
    check_level("one_read", read_count == 1, 1'b1);
    check_pkt("mem_out", last_read, '{ptype: pkt_read, id: 4'h4, addr: line_of(a),
              data: '0}, 1'b0);
  endtask

  task automatic test_hit_load();
    logic [`DC_WORD_W-1:0] word;
    logic                  fs;
    logic [`DC_ADDR_W-1:0] a;
    a = make_addr(26'h12_3456, 4'd3, 2'd0);
    access(1'b1, st_none, a, '0, word, fs);
    check_level("stall", fs, 1'b0);
    check_word("data_out", word, exp_word(a));
  endtask

  task automatic test_store_kinds();
    for (int ws = 0; ws < 4; ws++) begin
      store_check(st_lane32, make_addr(26'h12_3456, 4'd3, 2'(ws)),
                  {$urandom, $urandom, $urandom, $urandom});
    end
    store_check(st_half36, make_addr(26'h12_3456, 4'd3, 2'd1),
                {$urandom, $urandom, $urandom, $urandom});
    store_check(st_half36, make_addr(26'h12_3456, 4'd3, 2'd2),
                {$urandom, $urandom, $urandom, $urandom});
    store_check(st_full, make_addr(26'h12_3456, 4'd3, 2'd3),
                {$urandom, $urandom, $urandom, $urandom});
  endtask

  task automatic test_eviction();
    logic [`DC_ADDR_W-1:0] a;
    int unsigned           wb_before;
    a = make_addr(26'h100, 4'd9, 2'd1);
    load_check("data_out", a);
    store_check(st_lane32, a, {$urandom, $urandom, $urandom, $urandom});
    wb_before = write_count;
    // four more tags fill the set and push the dirty line out
    for (int t = 1; t < 5; t++) begin
      load_check("data_out", make_addr(26'h100 + 26'(t), 4'd9, 2'd0));
    end
    check_level("one_writeback", write_count == wb_before + 1, 1'b1);
    check_pkt("mem_out", last_write, '{ptype: pkt_write, id: 4'h4, addr: line_of(a),
              data: exp_lines[line_of(a)]}, 1'b1);
    load_check("data_out", a);
  endtask

  task automatic test_busy_slot();
    int unsigned           reads_before;
    int unsigned           writes_before;
    logic [`DC_ADDR_W-1:0] a;
    reads_before  = read_count;
    writes_before = write_count;
    a = make_addr(26'h2_0000, 4'd12, 2'd3);
    hold_slot_busy(5);
    load_check("data_out", a);
    store_check(st_full, a, {$urandom, $urandom, $urandom, $urandom});
    busy_en = 1'b1;
    for (int t = 1; t < 6; t++) begin
      // the fourth new tag evicts the dirty line while a long foreign spell holds the slot
      if (t == 4) begin
        hold_slot_busy(12);
      end
      load_check("data_out", make_addr(26'h2_0000 + 26'(t), 4'd12, 2'(t)));
    end
    busy_en = 1'b0;
    check_level("reads_sent", read_count == reads_before + 6, 1'b1);
    check_level("one_writeback", write_count == writes_before + 1, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h4412_a7a0));
    clk        = 1'b0;
    rst        = 1'b1;
    r          = 1'b0;
    w_type     = st_none;
    addr       = '0;
    w_data     = '0;
    mem_in     = '{ptype: pkt_none, id: 4'h0, addr: '0, data: '0};
    errors     = 0;
    checks     = 0;
    read_count = 0;
    write_count = 0;
    pend       = 1'b0;
    pend_dly   = 0;
    foreign    = 1'b0;
    busy_cnt   = 0;
    busy_en    = 1'b0;
    force_busy = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_cold_load();
    test_hit_load();
    test_store_kinds();
    test_eviction();
    test_busy_slot();
    repeat (4) @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/dcache_types_pkg.sv
src/mem_packet_pkg.sv
src/dcache_req_decode.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_miss_fsm.sv
src/dcache_store_merge.sv
src/dcache_top.sv
testbench/tb_dcache.sv
